// File: src/muldiv_settings.svh
//--------------------------------------------------------------------------
// width and iteration macros for the multiply/divide unit
// MULDIV_CNT_W must be wide enough to hold MULDIV_ITERS - 1
//--------------------------------------------------------------------------

`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

//--------------------------------------------------------------------------
// operand width
//--------------------------------------------------------------------------

// both operands and each result half are this wide
`define MULDIV_XLEN 32

//--------------------------------------------------------------------------
// iteration control
//--------------------------------------------------------------------------

// one iteration per operand bit, for both units
`define MULDIV_ITERS 32

// iteration counter width, counts ITERS-1 down to 0
`define MULDIV_CNT_W 6

`endif

// File: src/muldiv_pkg.sv
//--------------------------------------------------------------------------
// shared types of the multiply/divide unit
// fn codes are the values the pattern file uses
//--------------------------------------------------------------------------

`default_nettype none

`include "muldiv_settings.svh"

package muldiv_pkg;

  //------------------------------------------------------------------------
  // function codes
  //------------------------------------------------------------------------

  // 2'd3 is not a legal code
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_e;

  //------------------------------------------------------------------------
  // request, 66 bits with fn on top
  //------------------------------------------------------------------------

  typedef struct packed {
    muldiv_fn_e              fn;
    logic [`MULDIV_XLEN-1:0] a;
    logic [`MULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  //------------------------------------------------------------------------
  // result word, 64 bits, read as divide or multiply output
  //------------------------------------------------------------------------

  // divider view, remainder in the upper half
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] rem;
    logic [`MULDIV_XLEN-1:0] quo;
  } muldiv_div_view_t;

  // multiplier view, full signed product
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] hi;
    logic [`MULDIV_XLEN-1:0] lo;
  } muldiv_mul_view_t;

  typedef union packed {
    muldiv_div_view_t div_view;
    muldiv_mul_view_t mul_view;
  } muldiv_result_u;

endpackage

`default_nettype wire

// File: src/int_div_ctrl.sv
//--------------------------------------------------------------------------
// control unit of the restoring divider
// one request at a time, counter_is_zero comes from the datapath
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic cntr_mux_sel,
  output logic sign_en
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_DONE
  } div_state_e;

  div_state_e state_q;
  div_state_e state_d;
  logic       accept;
  logic       resp_xfer;

  // handshake events
  assign accept    = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  //------------------------------------------------------------------------
  // state register and next state
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (accept) state_d = S_CALC;
      // last iteration happens on the edge that leaves CALC
      S_CALC: if (counter_is_zero) state_d = S_DONE;
      // hold the result until the consumer takes it
      S_DONE: if (resp_xfer) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  //------------------------------------------------------------------------
  // outputs, decoded from state only
  //------------------------------------------------------------------------

  assign req_rdy  = (state_q == S_IDLE);
  assign resp_val = (state_q == S_DONE);

  // load on the acceptance edge, then iterate every CALC cycle
  assign a_en         = accept | (state_q == S_CALC);
  assign b_en         = accept;
  assign sign_en      = accept;
  // 0 picks initial operand / counter load, 1 picks iteration / decrement
  assign a_mux_sel    = (state_q == S_CALC);
  assign cntr_mux_sel = (state_q == S_CALC);

  //------------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------------

  // the counter load in the datapath must give exactly ITERS iterations
  a_calc_len: assert property (
    @(posedge clk) disable iff (reset)
    accept |=> (state_q == S_CALC) [* `MULDIV_ITERS] ##1 (state_q == S_DONE)
  );

endmodule

`default_nettype wire

// File: src/int_div_dpath.sv
//--------------------------------------------------------------------------
// datapath of the restoring divider
// divide by zero is not handled, result is whatever the iterations leave
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`MULDIV_XLEN-1:0]    a,
  input  logic [`MULDIV_XLEN-1:0]    b,
  input  logic                       is_signed,
  input  logic                       a_en,
  input  logic                       b_en,
  input  logic                       a_mux_sel,
  input  logic                       cntr_mux_sel,
  input  logic                       sign_en,
  output logic                       counter_is_zero,
  output muldiv_pkg::muldiv_result_u result
);

  localparam int W  = `MULDIV_XLEN;
  // one spare bit on top keeps the subtract sign
  localparam int RW = 2 * W + 1;
  localparam logic [`MULDIV_CNT_W-1:0] CNT_LOAD = `MULDIV_ITERS - 1;

  // working register, {remainder, quotient}
  logic [RW-1:0]            rq_q;
  // divisor magnitude
  logic [W-1:0]             dvsr_q;
  logic                     quo_neg_q;
  logic                     rem_neg_q;
  logic [`MULDIV_CNT_W-1:0] cnt_q;

  logic                     a_neg;
  logic                     b_neg;
  logic [W-1:0]             a_mag;
  logic [W-1:0]             b_mag;
  logic [RW-1:0]            rq_init;
  logic [RW-1:0]            rq_shift;
  logic [RW-1:0]            dvsr_al;
  logic [RW-1:0]            diff;
  logic [RW-1:0]            rq_next;
  logic [W-1:0]             quo_mag;
  logic [W-1:0]             rem_mag;

  //------------------------------------------------------------------------
  // operand magnitudes
  //------------------------------------------------------------------------

  // sign bits only count for a signed divide
  assign a_neg = is_signed & a[W-1];
  assign b_neg = is_signed & b[W-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // dividend starts in the quotient half, remainder half cleared
  assign rq_init = {{(W + 1){1'b0}}, a_mag};

  //------------------------------------------------------------------------
  // one shift-subtract step
  //------------------------------------------------------------------------

  assign rq_shift = rq_q << 1;
  // divisor lined up with the remainder half
  assign dvsr_al  = {1'b0, dvsr_q, {W{1'b0}}};
  assign diff     = rq_shift - dvsr_al;

  // negative difference, restore the shifted value, quotient bit 0
  // otherwise keep the difference and set quotient bit 1
  assign rq_next = diff[RW-1] ? rq_shift : {diff[RW-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_q <= a_mux_sel ? rq_next : rq_init;
    end
    if (b_en) begin
      dvsr_q <= b_mag;
    end
    // quotient negative when signs differ, remainder follows dividend
    if (sign_en) begin
      quo_neg_q <= a_neg ^ b_neg;
      rem_neg_q <= a_neg;
    end
  end

  //------------------------------------------------------------------------
  // iteration counter
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (a_en) begin
      cnt_q <= cntr_mux_sel ? (cnt_q - 1'b1) : CNT_LOAD;
    end
  end

  assign counter_is_zero = (cnt_q == '0);

  //------------------------------------------------------------------------
  // sign fix-up
  //------------------------------------------------------------------------

  assign quo_mag = rq_q[W-1:0];
  assign rem_mag = rq_q[2*W-1:W];

  always_comb begin
    result.div_view.quo = quo_neg_q ? (~quo_mag + 1'b1) : quo_mag;
    result.div_view.rem = rem_neg_q ? (~rem_mag + 1'b1) : rem_mag;
  end

endmodule

`default_nettype wire

// File: src/int_mul_iterative.sv
//--------------------------------------------------------------------------
// iterative shift-add multiplier, signed operands only
// fixed 32 iterations, no early exit on a zero multiplier
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  input  logic [`MULDIV_XLEN-1:0]    a,
  input  logic [`MULDIV_XLEN-1:0]    b,
  input  logic                       resp_rdy,
  output logic                       req_rdy,
  output logic                       resp_val,
  output muldiv_pkg::muldiv_result_u result
);

  localparam int W = `MULDIV_XLEN;
  localparam logic [`MULDIV_CNT_W-1:0] CNT_LOAD = `MULDIV_ITERS - 1;

  typedef enum logic [1:0] {
    M_IDLE,
    M_CALC,
    M_DONE
  } mul_state_e;

  mul_state_e               state_q;
  logic [`MULDIV_CNT_W-1:0] cnt_q;
  logic                     accept;

  // payload registers
  logic [2*W-1:0]           mcand_q;
  logic [W-1:0]             mplier_q;
  logic [2*W-1:0]           prod_q;
  logic                     neg_q;
  logic [2*W-1:0]           prod_out;

  assign req_rdy  = (state_q == M_IDLE);
  assign resp_val = (state_q == M_DONE);
  assign accept   = req_val & req_rdy;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: if (accept) begin
          state_q <= M_CALC;
          cnt_q   <= CNT_LOAD;
        end
        M_CALC: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0) state_q <= M_DONE;
        end
        M_DONE: if (resp_rdy) state_q <= M_IDLE;
        default: state_q <= M_IDLE;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // shift-add datapath
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      // work on magnitudes, sign goes back on at the output
      mcand_q  <= {{W{1'b0}}, (a[W-1] ? (~a + 1'b1) : a)};
      mplier_q <= b[W-1] ? (~b + 1'b1) : b;
      prod_q   <= '0;
      neg_q    <= a[W-1] ^ b[W-1];
    end else if (state_q == M_CALC) begin
      // add the shifted multiplicand for a set multiplier bit
      if (mplier_q[0]) prod_q <= prod_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign prod_out = neg_q ? (~prod_q + 1'b1) : prod_q;

  always_comb begin
    result.mul_view.hi = prod_out[2*W-1:W];
    result.mul_view.lo = prod_out[W-1:0];
  end

  // back-pressure must not disturb a finished product
  a_result_hold: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(result))
  );

endmodule

`default_nettype wire

// File: src/int_muldiv_top.sv
//--------------------------------------------------------------------------
// multiply/divide unit, one request in flight
// response 33 cycles after acceptance, req_rdy low until it is taken
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv_top (
  input  logic                       clk,
  input  logic                       reset,
  input  muldiv_pkg::muldiv_req_t    req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output muldiv_pkg::muldiv_result_u resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import muldiv_pkg::*;

  logic           busy_q;
  // 1 while the divider owns the current request
  logic           sel_div_q;
  logic           is_div;
  logic           is_signed;
  logic           accept;

  logic           div_req_val;
  logic           div_req_rdy;
  logic           div_resp_val;
  logic           div_resp_rdy;
  logic           a_en;
  logic           b_en;
  logic           a_mux_sel;
  logic           cntr_mux_sel;
  logic           sign_en;
  logic           counter_is_zero;
  muldiv_result_u div_result;

  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           mul_resp_rdy;
  muldiv_result_u mul_result;

  //------------------------------------------------------------------------
  // decode and busy tracking
  //------------------------------------------------------------------------

  assign is_div    = (req.fn != FN_MUL);
  assign is_signed = (req.fn == FN_DIV);

  // both units sit idle whenever the top is not busy
  assign req_rdy = !busy_q & div_req_rdy & mul_req_rdy;
  assign accept  = req_val & req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q    <= 1'b0;
      sel_div_q <= 1'b0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      sel_div_q <= is_div;
    end else if (resp_val && resp_rdy) begin
      busy_q    <= 1'b0;
    end
  end

  // request valid only to the unit the function belongs to
  assign div_req_val  = req_val & !busy_q & is_div;
  assign mul_req_val  = req_val & !busy_q & !is_div;
  // response ready only to the busy unit
  assign div_resp_rdy = resp_rdy & busy_q & sel_div_q;
  assign mul_resp_rdy = resp_rdy & busy_q & !sel_div_q;

  //------------------------------------------------------------------------
  // units
  //------------------------------------------------------------------------

  int_div_ctrl i_div_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (div_req_val),
    .resp_rdy        (div_resp_rdy),
    .counter_is_zero (counter_is_zero),
    .req_rdy         (div_req_rdy),
    .resp_val        (div_resp_val),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en)
  );

  int_div_dpath i_div_dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (req.a),
    .b               (req.b),
    .is_signed       (is_signed),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .counter_is_zero (counter_is_zero),
    .result          (div_result)
  );

  int_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .a        (req.a),
    .b        (req.b),
    .resp_rdy (mul_resp_rdy),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .result   (mul_result)
  );

  // response mux, follows the selected unit
  assign resp_val = sel_div_q ? div_resp_val : mul_resp_val;
  assign resp     = sel_div_q ? div_result : mul_result;

  a_resp_from_sel: assert property (
    @(posedge clk) disable iff (reset)
    (div_resp_val |-> (busy_q && sel_div_q)) and
    (mul_resp_val |-> (busy_q && !sel_div_q))
  );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
//--------------------------------------------------------------------------
// free-running testbench clock, 8 ns period, starts low
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // half of the 8 ns period
  localparam int HALF_PERIOD_NS = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: sim/muldiv_tb.sv
//--------------------------------------------------------------------------
// testbench for int_muldiv_top, patterns come from sim/muldiv_patterns.txt
// run from the project root so the pattern path resolves
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_tb;

  import muldiv_pkg::*;

  localparam string PATTERN_FILE   = "sim/muldiv_patterns.txt";
  localparam int    TIMEOUT_CYCLES = 200;
  localparam int    RESET_CYCLES   = 10;
  localparam int    SEED           = 79135;
  // acceptance cycle, ITERS iteration cycles, then the response cycle
  localparam int    RESP_LATENCY   = `MULDIV_ITERS + 1;
  localparam int    MAX_HOLD       = 5;

  logic           clk;
  logic           reset;
  muldiv_req_t    req;
  logic           req_val;
  logic           req_rdy;
  muldiv_result_u resp;
  logic           resp_val;
  logic           resp_rdy;

  // pattern store, filled before reset is released
  muldiv_req_t    pat_req[$];
  logic [63:0]    pat_exp[$];
  int unsigned    rng_init;

  tb_clock i_clk (
    .clk (clk)
  );

  int_muldiv_top i_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  //------------------------------------------------------------------------
  // failure reporting and the compare task
  //------------------------------------------------------------------------

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    fail_run();
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      fail_run();
    end
  endtask

  //------------------------------------------------------------------------
  // pattern file, '#' lines are comments
  //------------------------------------------------------------------------

  task automatic load_patterns();
    int                      fd;
    int                      n;
    string                   line;
    logic [1:0]              fn_v;
    logic [`MULDIV_XLEN-1:0] a_v;
    logic [`MULDIV_XLEN-1:0] b_v;
    logic [`MULDIV_XLEN-1:0] hi_v;
    logic [`MULDIV_XLEN-1:0] lo_v;
    muldiv_req_t             r;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      report_failure({"could not open the pattern file ", PATTERN_FILE});
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", fn_v, a_v, b_v, hi_v, lo_v);
        if (n == 5) begin
          if (fn_v == 2'd3) begin
            report_failure({"illegal function code in pattern line: ", line});
          end
          r.fn = muldiv_fn_e'(fn_v);
          r.a  = a_v;
          r.b  = b_v;
          pat_req.push_back(r);
          pat_exp.push_back({hi_v, lo_v});
        end else if (n > 0) begin
          report_failure({"malformed pattern line: ", line});
        end
      end
    end
    $fclose(fd);
    if (pat_req.size() == 0) begin
      report_failure("the pattern file holds no patterns");
    end
  endtask

  // junk request, the DUT must have latched its operands already
  function automatic muldiv_req_t random_req();
    muldiv_req_t r;
    r.fn = muldiv_fn_e'($urandom % 3);
    r.a  = $urandom;
    r.b  = $urandom;
    return r;
  endfunction

  //------------------------------------------------------------------------
  // one request, entered and left on a falling edge
  //------------------------------------------------------------------------

  task automatic run_pattern(input int idx);
    int          cycles;
    int          hold;
    logic [63:0] held;
    string       tag;
    tag = $sformatf("pattern %0d", idx);
    req     = pat_req[idx];
    req_val = 1'b1;
    // req_rdy does not depend on req_val, so it is settled here
    cycles = 0;
    while (!req_rdy) begin
      @(negedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("%s: req_rdy never went high within %0d cycles",
                                 tag, TIMEOUT_CYCLES));
      end
    end
    // acceptance on the next rising edge, count falling edges after it
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles == 1) begin
        req_val = 1'b0;
        req     = random_req();
      end
      check_equal(req_rdy, 1'b0, {tag, ": req_rdy while busy"});
      if (cycles >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("%s: resp_val never went high within %0d cycles",
                                 tag, TIMEOUT_CYCLES));
      end
    end while (!resp_val);
    check_equal(cycles, RESP_LATENCY, {tag, ": cycles from acceptance to resp_val"});
    check_equal(resp, pat_exp[idx], {tag, ": result word"});
    // back-pressure, response must sit still
    held = resp;
    hold = $urandom % (MAX_HOLD + 1);
    repeat (hold) begin
      @(negedge clk);
      check_equal(resp_val, 1'b1, {tag, ": resp_val dropped under back-pressure"});
      check_equal(resp, held, {tag, ": result changed under back-pressure"});
      check_equal(req_rdy, 1'b0, {tag, ": req_rdy under back-pressure"});
    end
    resp_rdy = 1'b1;
    // response transfer on the rising edge in between
    @(negedge clk);
    resp_rdy = 1'b0;
    check_equal(resp_val, 1'b0, {tag, ": resp_val after transfer"});
    check_equal(req_rdy, 1'b1, {tag, ": req_rdy after transfer"});
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------

  initial begin
    rng_init = $urandom(SEED);
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    load_patterns();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    check_equal(req_rdy, 1'b1, "req_rdy after reset");
    check_equal(resp_val, 1'b0, "resp_val after reset");
    // back to back, each pattern starts on the edge the last one ended
    for (int i = 0; i < pat_req.size(); i++) begin
      run_pattern(i);
    end
    $display("%0d patterns checked", pat_req.size());
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/muldiv_pkg.sv
src/int_div_ctrl.sv
src/int_div_dpath.sv
src/int_mul_iterative.sv
src/int_muldiv_top.sv
sim/tb_clock.sv
sim/muldiv_tb.sv

// File: sim/muldiv_patterns.txt
# columns: fn (0 MUL, 1 DIV, 2 DIVU), a, b, expected upper half, expected lower half
# upper/lower half is hi/lo for MUL and remainder/quotient for DIV and DIVU
# unsigned divide
2 ffffffff 00000001 00000000 ffffffff
2 ffffffff 00000010 0000000f 0fffffff
2 00000005 00000009 00000005 00000000
2 00000064 00000007 00000002 0000000e
2 80000000 00000003 00000002 2aaaaaaa
2 ffffffff ffffffff 00000000 00000001
2 12345678 00010000 00005678 00001234
2 7fffffff 80000000 7fffffff 00000000
# signed divide, all sign combinations
1 00000064 00000007 00000002 0000000e
1 ffffff9c 00000007 fffffffe fffffff2
1 00000064 fffffff9 00000002 fffffff2
1 ffffff9c fffffff9 fffffffe 0000000e
1 80000000 ffffffff 00000000 80000000
1 80000000 00000002 00000000 c0000000
1 fffffff9 00000002 ffffffff fffffffd
1 00000007 fffffffe 00000001 fffffffd
1 00000003 fffffff6 00000003 00000000
1 fffffffd 0000000a fffffffd 00000000
1 7fffffff 80000000 7fffffff 00000000
# signed multiply
0 00000003 00000005 00000000 0000000f
0 fffffffd 00000005 ffffffff fffffff1
0 fffffffd fffffffb 00000000 0000000f
0 7fffffff 7fffffff 3fffffff 00000001
0 80000000 80000000 40000000 00000000
0 80000000 7fffffff c0000000 80000000
0 80000000 ffffffff 00000000 80000000
0 ffffffff ffffffff 00000000 00000001
0 12345678 00000000 00000000 00000000
0 00010000 00010000 00000001 00000000
0 ffff0000 00010000 ffffffff 00000000
0 12345678 00000010 00000001 23456780
0 ffffffff 12345678 ffffffff edcba988
# unit switch after multiply
2 00000064 00000007 00000002 0000000e
